/* rtl/ipod_pkg.sv */
`default_nettype none

package ipod_pkg;

  // ====================
  // Widths
  // ====================
  localparam int ADDR_W   = 23;
  localparam int DATA_W   = 32;
  localparam int SAMPLE_W = 8;
  localparam int PERIOD_W = 16;

  typedef logic [ADDR_W-1:0]          addr_t;
  typedef logic [DATA_W-1:0]          word_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  // Unsigned so that magnitude 128 fits
  typedef logic [SAMPLE_W-1:0]        intensity_t;
  typedef logic [PERIOD_W-1:0]        period_t;

  // ====================
  // Limits
  // ====================
  // About 22 kHz at 50 MHz
  localparam period_t DEFAULT_PERIOD    = 16'd2272;
  localparam period_t SPEED_STEP        = 16'd16;
  localparam period_t MIN_PERIOD        = 16'd32;
  localparam period_t MAX_PERIOD        = 16'd65535;
  localparam addr_t   FIRST_ADDR        = '0;
  localparam addr_t   LAST_ADDR_DEFAULT = '1;

  // ====================
  // Enums and structs
  // ====================
  typedef enum logic [2:0] {
    HOLD,
    INC,
    DEC,
    LOAD_FIRST,
    LOAD_LAST
  } addr_op_t;

  typedef enum logic [2:0] {
    IDLE,
    READ_REQ,
    READ_WAIT,
    EMIT_FIRST,
    WAIT_TICK,
    EMIT_SECOND
  } fsm_state_t;

  // play and reverse are levels, restart is a pulse
  typedef struct packed {
    logic play;
    logic reverse;
    logic restart;
  } play_ctrl_t;

  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_cmd_t;

  typedef struct packed {
    logic  read;
    addr_t address;
  } flash_req_t;

  typedef struct packed {
    logic  waitrequest;
    logic  readdatavalid;
    word_t readdata;
  } flash_rsp_t;

  typedef struct packed {
    sample_t    sample;
    intensity_t intensity;
  } sample_out_t;

endpackage

`default_nettype wire

/* rtl/sample_rate_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_rate_timer #(
  parameter ipod_pkg::period_t DEFAULT_PERIOD = ipod_pkg::DEFAULT_PERIOD
) (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::speed_cmd_t speed,
  output logic                 sample_tick
);

  ipod_pkg::period_t period_q;
  ipod_pkg::period_t period_d;
  ipod_pkg::period_t count_q;

  // ====================
  // Period register
  // ====================
  // Reset wins over up and down if they come together
  always_comb
  begin
    period_d = period_q;
    if (speed.reset)
    begin
      period_d = DEFAULT_PERIOD;
    end
    else if (speed.up)
    begin
      if (period_q < ipod_pkg::MIN_PERIOD + ipod_pkg::SPEED_STEP)
        period_d = ipod_pkg::MIN_PERIOD;
      else
        period_d = period_q - ipod_pkg::SPEED_STEP;
    end
    else if (speed.down)
    begin
      // Check before adding so the sum cannot overflow
      if (period_q > ipod_pkg::MAX_PERIOD - ipod_pkg::SPEED_STEP)
        period_d = ipod_pkg::MAX_PERIOD;
      else
        period_d = period_q + ipod_pkg::SPEED_STEP;
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      period_q <= DEFAULT_PERIOD;
    else
      period_q <= period_d;
  end

  // ====================
  // Tick counter
  // ====================
  // Down counter, reloaded on wrap, so a new period
  // only applies from the next wrap on
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      count_q <= DEFAULT_PERIOD - 1'b1;
    else if (count_q == '0)
      count_q <= period_q - 1'b1;
    else
      count_q <= count_q - 1'b1;
  end

  assign sample_tick = (count_q == '0);

endmodule

`default_nettype wire

/* rtl/playback_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module playback_fsm (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::play_ctrl_t play,
  input  logic                 sample_tick,
  input  logic                 flash_rsp_waitrequest,
  input  logic                 flash_rsp_readdatavalid,
  input  ipod_pkg::addr_t      address,
  output ipod_pkg::flash_req_t flash_req,
  output ipod_pkg::addr_op_t   addr_op,
  output logic                 word_load,
  output logic                 emit,
  output logic                 half_sel
);

  ipod_pkg::fsm_state_t state_q;
  ipod_pkg::fsm_state_t state_d;
  ipod_pkg::addr_op_t   load_op;
  // Direction of the word in flight, 1 for reverse
  logic                 dir_q;
  logic                 dir_d;
  logic                 restart_pend_q;
  logic                 restart_pend_d;
  logic                 fetching;

  assign fetching = (state_q == ipod_pkg::READ_REQ) || (state_q == ipod_pkg::READ_WAIT);
  assign load_op  = play.reverse ? ipod_pkg::LOAD_LAST : ipod_pkg::LOAD_FIRST;

  // Read is held high with a stable address until accepted
  assign flash_req.read    = (state_q == ipod_pkg::READ_REQ);
  assign flash_req.address = address;

  always_comb
  begin
    state_d        = state_q;
    dir_d          = dir_q;
    restart_pend_d = restart_pend_q;
    addr_op        = ipod_pkg::HOLD;
    word_load      = 1'b0;
    emit           = 1'b0;
    half_sel       = dir_q;

    unique case (state_q)
      ipod_pkg::IDLE:
      begin
        if (sample_tick && play.play)
        begin
          state_d = ipod_pkg::READ_REQ;
          dir_d   = play.reverse;
        end
      end
      ipod_pkg::READ_REQ:
      begin
        if (!flash_rsp_waitrequest)
          state_d = ipod_pkg::READ_WAIT;
      end
      ipod_pkg::READ_WAIT:
      begin
        if (flash_rsp_readdatavalid)
        begin
          if (restart_pend_q || play.restart)
          begin
            // Word is dropped, playback restarts from an end
            restart_pend_d = 1'b0;
            addr_op        = load_op;
            state_d        = ipod_pkg::IDLE;
          end
          else
          begin
            // Forward plays 31:24 first, reverse 15:8 first
            word_load = 1'b1;
            emit      = 1'b1;
            half_sel  = dir_q;
            state_d   = ipod_pkg::EMIT_FIRST;
          end
        end
      end
      ipod_pkg::EMIT_FIRST:
      begin
        state_d = ipod_pkg::WAIT_TICK;
      end
      ipod_pkg::WAIT_TICK:
      begin
        if (sample_tick && play.play)
        begin
          emit     = 1'b1;
          half_sel = ~dir_q;
          state_d  = ipod_pkg::EMIT_SECOND;
        end
      end
      ipod_pkg::EMIT_SECOND:
      begin
        addr_op = dir_q ? ipod_pkg::DEC : ipod_pkg::INC;
        state_d = ipod_pkg::IDLE;
      end
      default:
      begin
        state_d = ipod_pkg::IDLE;
      end
    endcase

    // Restart outside a fetch takes effect at once
    if (play.restart && !fetching)
    begin
      addr_op = load_op;
      emit    = 1'b0;
      state_d = ipod_pkg::IDLE;
    end
    else if (play.restart && !(state_q == ipod_pkg::READ_WAIT && flash_rsp_readdatavalid))
    begin
      restart_pend_d = 1'b1;
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q        <= ipod_pkg::IDLE;
      dir_q          <= 1'b0;
      restart_pend_q <= 1'b0;
    end
    else
    begin
      state_q        <= state_d;
      dir_q          <= dir_d;
      restart_pend_q <= restart_pend_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/playback_address.sv */
`timescale 1ns/1ps
`default_nettype none

module playback_address #(
  parameter ipod_pkg::addr_t LAST_ADDR = ipod_pkg::LAST_ADDR_DEFAULT
) (
  input  logic               CLK_50M,
  input  logic               arst_n,
  input  ipod_pkg::addr_op_t addr_op,
  output ipod_pkg::addr_t    address
);

  ipod_pkg::addr_t addr_next;

  // ====================
  // Next address
  // ====================
  // Both ends wrap to the opposite end
  always_comb
  begin
    unique case (addr_op)
      ipod_pkg::INC:
      begin
        if (address == LAST_ADDR)
          addr_next = ipod_pkg::FIRST_ADDR;
        else
          addr_next = address + 1'b1;
      end
      ipod_pkg::DEC:
      begin
        if (address == ipod_pkg::FIRST_ADDR)
          addr_next = LAST_ADDR;
        else
          addr_next = address - 1'b1;
      end
      ipod_pkg::LOAD_FIRST:
      begin
        addr_next = ipod_pkg::FIRST_ADDR;
      end
      ipod_pkg::LOAD_LAST:
      begin
        addr_next = LAST_ADDR;
      end
      default:
      begin
        addr_next = address;
      end
    endcase
  end

  // ====================
  // Address register
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      address <= ipod_pkg::FIRST_ADDR;
    else
      address <= addr_next;
  end

endmodule

`default_nettype wire

/* rtl/sample_output.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_output (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  ipod_pkg::word_t       readdata,
  input  logic                  word_load,
  input  logic                  emit,
  input  logic                  half_sel,
  output ipod_pkg::sample_out_t audio,
  output logic                  audio_valid
);

  ipod_pkg::word_t      word_q;
  ipod_pkg::word_t      src_word;
  ipod_pkg::sample_t    sel_sample;
  ipod_pkg::intensity_t sel_mag;

  // Held word for the second half
  always_ff @(posedge CLK_50M)
  begin
    if (word_load)
      word_q <= readdata;
  end

  // First sample comes straight from the bus
  assign src_word   = word_load ? readdata : word_q;
  assign sel_sample = half_sel ? src_word[15:8] : src_word[31:24];

  // -128 gives 8'h80, read unsigned as 128
  assign sel_mag = sel_sample[7] ? ipod_pkg::intensity_t'(~sel_sample + 1'b1)
                                 : ipod_pkg::intensity_t'(sel_sample);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      audio       <= '0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= emit;
      if (emit)
      begin
        audio.sample    <= sel_sample;
        audio.intensity <= sel_mag;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/ipod_player_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ipod_player_top #(
  parameter ipod_pkg::period_t DEFAULT_PERIOD = ipod_pkg::DEFAULT_PERIOD,
  parameter ipod_pkg::addr_t   LAST_ADDR      = ipod_pkg::LAST_ADDR_DEFAULT
) (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  ipod_pkg::play_ctrl_t  play,
  input  ipod_pkg::speed_cmd_t  speed,
  input  ipod_pkg::flash_rsp_t  flash_rsp,
  output ipod_pkg::flash_req_t  flash_req,
  output ipod_pkg::sample_out_t audio,
  output logic                  audio_valid
);

  logic               sample_tick;
  ipod_pkg::addr_op_t addr_op;
  ipod_pkg::addr_t    address;
  logic               word_load;
  logic               emit;
  logic               half_sel;

  // ====================
  // Pacing
  // ====================
  sample_rate_timer #(
    .DEFAULT_PERIOD(DEFAULT_PERIOD)
  ) timer0 (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .speed      (speed),
    .sample_tick(sample_tick)
  );

  // ====================
  // Control and datapath
  // ====================
  playback_fsm fsm0 (
    .CLK_50M                (CLK_50M),
    .arst_n                 (arst_n),
    .play                   (play),
    .sample_tick            (sample_tick),
    .flash_rsp_waitrequest  (flash_rsp.waitrequest),
    .flash_rsp_readdatavalid(flash_rsp.readdatavalid),
    .address                (address),
    .flash_req              (flash_req),
    .addr_op                (addr_op),
    .word_load              (word_load),
    .emit                   (emit),
    .half_sel               (half_sel)
  );

  playback_address #(
    .LAST_ADDR(LAST_ADDR)
  ) addr0 (
    .CLK_50M(CLK_50M),
    .arst_n (arst_n),
    .addr_op(addr_op),
    .address(address)
  );

  sample_output out0 (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .readdata   (flash_rsp.readdata),
    .word_load  (word_load),
    .emit       (emit),
    .half_sel   (half_sel),
    .audio      (audio),
    .audio_valid(audio_valid)
  );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic CLK_50M
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever
      #10 CLK_50M = ~CLK_50M;
  end

endmodule

`default_nettype wire

/* bench/flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_model (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::flash_req_t flash_req,
  output ipod_pkg::flash_rsp_t flash_rsp
);

  ipod_pkg::word_t mem [0:7];
  integer          seed;
  logic [1:0]      wait_left;
  logic [1:0]      lat_left;
  logic            pending;
  logic [2:0]      addr_q;
  logic            valid_q;
  ipod_pkg::word_t data_q;

  initial
  begin
    seed = 32'ha41d;
    for (int i = 0; i < 8; i++)
      mem[i] = $random(seed);
    // One sample at -128
    mem[3][31:24] = 8'h80;
  end

  // Back-pressure until the drawn wait count runs out
  assign flash_rsp.waitrequest   = flash_req.read && (wait_left != 2'd0);
  assign flash_rsp.readdatavalid = valid_q;
  assign flash_rsp.readdata      = data_q;

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_left <= 2'd1;
      lat_left  <= 2'd0;
      pending   <= 1'b0;
      addr_q    <= '0;
      valid_q   <= 1'b0;
      data_q    <= '0;
    end
    else
    begin
      valid_q <= 1'b0;
      if (flash_req.read && wait_left != 2'd0)
        wait_left <= wait_left - 2'd1;
      else if (flash_req.read)
      begin
        // Accepted, wait states of the next read drawn here
        wait_left <= 2'($random(seed));
        lat_left  <= 2'($random(seed));
        addr_q    <= flash_req.address[2:0];
        pending   <= 1'b1;
      end
      if (pending)
      begin
        if (lat_left == 2'd0)
        begin
          valid_q <= 1'b1;
          data_q  <= mem[addr_q];
          pending <= 1'b0;
        end
        else
          lat_left <= lat_left - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/ipod_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module ipod_asserts (
  input logic                 CLK_50M,
  input logic                 arst_n,
  input ipod_pkg::flash_req_t flash_req,
  input ipod_pkg::flash_rsp_t flash_rsp,
  input logic                 audio_valid
);

  logic outstanding;
  // Sticky, set by any failing property
  logic failed = 1'b0;

  // Accepted read waiting for its readdatavalid
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      outstanding <= 1'b0;
    else if (flash_req.read && !flash_rsp.waitrequest)
      outstanding <= 1'b1;
    else if (flash_rsp.readdatavalid)
      outstanding <= 1'b0;
  end

  // ====================
  // Flash bus
  // ====================
  read_held: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
  else
  begin
    $error("read or address changed while waitrequest was high");
    failed = 1'b1;
  end

  one_outstanding: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    outstanding |-> !flash_req.read)
  else
  begin
    $error("read issued while a readdatavalid was outstanding");
    failed = 1'b1;
  end

  // ====================
  // Audio and reset
  // ====================
  valid_pulse: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    audio_valid |=> !audio_valid)
  else
  begin
    $error("audio_valid lasted more than one cycle");
    failed = 1'b1;
  end

  quiet_after_reset: assert property (@(posedge CLK_50M)
    $rose(arst_n) |-> !flash_req.read && !audio_valid)
  else
  begin
    $error("read or audio_valid high after reset");
    failed = 1'b1;
  end

endmodule

bind ipod_player_top ipod_asserts asserts0 (
  .CLK_50M    (CLK_50M),
  .arst_n     (arst_n),
  .flash_req  (flash_req),
  .flash_rsp  (flash_rsp),
  .audio_valid(audio_valid)
);

`default_nettype wire

/* bench/ipod_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ipod_tb;

  logic                  CLK_50M;
  logic                  arst_n;
  ipod_pkg::play_ctrl_t  play;
  ipod_pkg::speed_cmd_t  speed;
  ipod_pkg::flash_rsp_t  flash_rsp;
  ipod_pkg::flash_req_t  flash_req;
  ipod_pkg::sample_out_t audio;
  logic                  audio_valid;

  // Reference model
  int exp_addr;
  bit exp_rev;
  bit exp_second;
  int exp_period;
  bit paused;
  bit read_q;
  bit timed;
  int cycle_cnt;
  int read_cycle;
  int words_done;

  clock_gen clk0 (.CLK_50M(CLK_50M));

  flash_model flash0 (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .flash_req(flash_req),
    .flash_rsp(flash_rsp)
  );

  ipod_player_top #(
    .DEFAULT_PERIOD(16'd64),
    .LAST_ADDR     (23'd7)
  ) dut0 (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .play       (play),
    .speed      (speed),
    .flash_rsp  (flash_rsp),
    .flash_req  (flash_req),
    .audio      (audio),
    .audio_valid(audio_valid)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  function automatic string fail_line(input string msg);
    return $sformatf("CHECK FAILED at %0t: %s", $time, msg);
  endfunction

  function automatic int magnitude(input logic signed [7:0] s);
    int v;
    v = s;
    return (v < 0) ? -v : v;
  endfunction

  function automatic int next_addr(input int a, input bit rev);
    if (rev)
      return (a == 0) ? 7 : a - 1;
    else
      return (a == 7) ? 0 : a + 1;
  endfunction

  // Forward plays 31:24 first, reverse 15:8 first
  function automatic logic [7:0] expected_byte(input int a, input bit rev, input bit second);
    logic [31:0] w;
    w = flash0.mem[a];
    if (rev ^ second)
      return w[15:8];
    else
      return w[31:24];
  endfunction

  task automatic check_sample();
    logic [7:0] want;
    want = expected_byte(exp_addr, exp_rev, exp_second);
    assert (!paused)
      else abort_run(fail_line("audio_valid while paused"));
    assert (audio.sample == want)
      else abort_run(fail_line($sformatf("sample %h, expected %h from word %0d",
                                         audio.sample, want, exp_addr)));
    assert (int'(audio.intensity) == magnitude(audio.sample))
      else abort_run(fail_line($sformatf("intensity %0d for sample %0d",
                                         audio.intensity, audio.sample)));
    if (exp_second)
    begin
      // A word cut by a pause has no fixed period
      if (timed)
      begin
        assert (cycle_cnt - read_cycle == exp_period)
          else abort_run(fail_line($sformatf("second sample %0d cycles after read, period %0d",
                                             cycle_cnt - read_cycle, exp_period)));
      end
      exp_addr = next_addr(exp_addr, exp_rev);
      words_done++;
    end
    exp_second = !exp_second;
  endtask

  // ====================
  // Monitor
  // ====================
  always @(posedge CLK_50M)
  begin
    cycle_cnt++;
    assert (!dut0.asserts0.failed)
      else abort_run("A bus or pulse property in ipod_asserts failed");
    if (flash_req.read && !read_q)
    begin
      read_cycle = cycle_cnt;
      timed      = 1'b1;
      assert (!paused)
        else abort_run(fail_line("read started while paused"));
      assert (flash_req.address == exp_addr)
        else abort_run(fail_line($sformatf("read from word %0d, expected %0d",
                                           flash_req.address, exp_addr)));
    end
    read_q = flash_req.read;
    if (audio_valid)
      check_sample();
  end

  // Returns 2 ns after the edge where the last word finished
  task automatic play_words(input int n);
    int target;
    int cycles;
    target = words_done + n;
    cycles = 0;
    while (words_done < target)
    begin
      @(posedge CLK_50M);
      #1;
      cycles++;
      if (cycles > n * 1000)
        abort_run("Timeout: audio samples stopped arriving during playback");
    end
    #1;
  endtask

  // Returns 2 ns after the edge where the first half of a word arrived
  task automatic wait_first_half();
    int cycles;
    cycles = 0;
    while (!exp_second)
    begin
      @(posedge CLK_50M);
      #1;
      cycles++;
      if (cycles > 1000)
        abort_run("Timeout: the first sample of a word never arrived");
    end
    #1;
  endtask

  task automatic restart_at(input bit rev);
    play.reverse = rev;
    play.restart = 1'b1;
    exp_rev      = rev;
    exp_addr     = rev ? 7 : 0;
    exp_second   = 1'b0;
    @(posedge CLK_50M);
    #2;
    play.restart = 1'b0;
  endtask

  task automatic speed_pulse(input bit up, input bit down, input bit rst);
    speed.up    = up;
    speed.down  = down;
    speed.reset = rst;
    if (rst)
      exp_period = 64;
    else if (up)
      exp_period = (exp_period - 16 < 32) ? 32 : exp_period - 16;
    else if (down)
      exp_period = (exp_period + 16 > 65535) ? 65535 : exp_period + 16;
    @(posedge CLK_50M);
    #2;
    speed = '0;
  endtask

  task automatic pause_for(input int cycles);
    play.play = 1'b0;
    paused    = 1'b1;
    timed     = 1'b0;
    repeat (cycles) @(posedge CLK_50M);
    #2;
    play.play = 1'b1;
    paused    = 1'b0;
  endtask

  // ====================
  // Stimulus
  // ====================
  initial
  begin
    arst_n     = 1'b0;
    play       = '0;
    speed      = '0;
    exp_addr   = 0;
    exp_rev    = 1'b0;
    exp_second = 1'b0;
    exp_period = 64;
    paused     = 1'b0;
    read_q     = 1'b0;
    timed      = 1'b0;
    cycle_cnt  = 0;
    read_cycle = 0;
    words_done = 0;
    repeat (8) @(posedge CLK_50M);
    #2;
    arst_n    = 1'b1;
    play.play = 1'b1;

    // Forward through the wrap from 7 to 0
    play_words(10);

    speed_pulse(1'b1, 1'b0, 1'b0);
    play_words(2);
    speed_pulse(1'b0, 1'b1, 1'b0);
    play_words(2);
    // Three steps down from 64 hit the floor
    speed_pulse(1'b1, 1'b0, 1'b0);
    speed_pulse(1'b1, 1'b0, 1'b0);
    speed_pulse(1'b1, 1'b0, 1'b0);
    play_words(2);
    speed_pulse(1'b0, 1'b0, 1'b1);
    play_words(2);

    restart_at(1'b0);
    play_words(2);
    // Reverse through the wrap from 0 to 7
    restart_at(1'b1);
    play_words(10);
    restart_at(1'b1);
    play_words(1);
    restart_at(1'b0);
    play_words(2);

    // Pause between words, then between the two halves of a word
    pause_for(400);
    play_words(1);
    wait_first_half();
    pause_for(400);
    play_words(2);

    if (dut0.asserts0.failed)
      abort_run("A bus or pulse property in ipod_asserts failed");
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/ipod_pkg.sv
rtl/sample_rate_timer.sv
rtl/playback_fsm.sv
rtl/playback_address.sv
rtl/sample_output.sv
rtl/ipod_player_top.sv
bench/clock_gen.sv
bench/flash_model.sv
bench/ipod_asserts.sv
bench/ipod_tb.sv
